/* common/fetch_pkg.sv */
package fetch_pkg;

    localparam int OFFSET_BITS = 2;
    localparam int INDEX_BITS = 4;
    localparam int TAG_BITS = 32 - INDEX_BITS - OFFSET_BITS;
    localparam int NUM_SETS = 1 << INDEX_BITS;

    // The fetch address is seen as a bus word and as cache fields.
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [TAG_BITS-1:0]    tag;
            logic [INDEX_BITS-1:0]  index;
            logic [OFFSET_BITS-1:0] offset;
        } f;
    } fetch_addr_t;

    localparam logic [1:0] RESP_OKAY = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

/* icache/icache_way.sv */
module icache_way import fetch_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        flush,
    input  logic        rd_en,
    input  fetch_addr_t rd_addr,
    input  logic        wr_en,
    input  fetch_addr_t wr_addr,
    input  logic [31:0] wr_data,
    output logic        way_hit,
    output logic [31:0] way_data
);

    logic [NUM_SETS-1:0] valid;
    logic [TAG_BITS-1:0] tag_mem [NUM_SETS];
    logic [31:0]         data_mem [NUM_SETS];

    logic                rd_valid;
    logic [TAG_BITS-1:0] rd_tag;
    logic [TAG_BITS-1:0] lookup_tag;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid <= '0;
            rd_valid <= 1'b0;
        end else if (flush) begin
            valid <= '0;
            rd_valid <= 1'b0; // Drop a read already in flight.
        end else begin
            if (wr_en) begin
                valid[wr_addr.f.index] <= 1'b1;
            end
            if (rd_en) begin
                rd_valid <= valid[rd_addr.f.index];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_addr.f.index] <= wr_addr.f.tag;
            data_mem[wr_addr.f.index] <= wr_data;
        end
        if (rd_en) begin
            rd_tag <= tag_mem[rd_addr.f.index];
            lookup_tag <= rd_addr.f.tag;
            way_data <= data_mem[rd_addr.f.index];
        end
    end

    assign way_hit = rd_valid && (rd_tag == lookup_tag);

endmodule

/* icache/icache.sv */
module icache import fetch_pkg::*; #(
    parameter int NUM_WAYS = 2
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        flush,

    input  logic        lookup_valid,
    input  fetch_addr_t lookup_addr,
    output logic        hit,
    output logic [31:0] hit_data,

    input  logic        fill_valid,
    input  fetch_addr_t fill_addr,
    input  logic [31:0] fill_data
);

    localparam int PTR_BITS = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;
    localparam logic [PTR_BITS-1:0] LAST_WAY = PTR_BITS'(NUM_WAYS - 1);

    logic [NUM_WAYS-1:0] way_hit;
    logic [31:0]         way_data [NUM_WAYS];
    logic [PTR_BITS-1:0] rr_ptr [NUM_SETS];
    logic [PTR_BITS-1:0] victim;

    assign victim = rr_ptr[fill_addr.f.index];

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        localparam logic [PTR_BITS-1:0] WAY_ID = PTR_BITS'(w);

        icache_way u_way (
            .clk      (clk),
            .rst      (rst),
            .flush    (flush),
            .rd_en    (lookup_valid),
            .rd_addr  (lookup_addr),
            .wr_en    (fill_valid && (victim == WAY_ID)),
            .wr_addr  (fill_addr),
            .wr_data  (fill_data),
            .way_hit  (way_hit[w]),
            .way_data (way_data[w])
        );
    end

    assign hit = |way_hit;

    always_comb begin
        hit_data = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (way_hit[w]) begin
                hit_data = way_data[w];
            end
        end
    end

    // One pointer per set, moved on by each fill of that set.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                rr_ptr[s] <= '0;
            end
        end else if (fill_valid) begin
            if (victim == LAST_WAY) begin
                rr_ptr[fill_addr.f.index] <= '0;
            end else begin
                rr_ptr[fill_addr.f.index] <= victim + 1'b1;
            end
        end
    end

    a_one_hit: assert property (@(posedge clk) disable iff (rst) $onehot0(way_hit));

endmodule

/* ifu/ifu.sv */
module ifu import fetch_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        flush,

    input  logic        req_valid,
    output logic        req_ready,
    input  logic [31:0] pc,

    output logic        inst_valid,
    input  logic        inst_ready,
    output logic [31:0] inst,
    output logic        inst_fault,

    output logic [31:0] araddr,
    output logic        arvalid,
    input  logic        arready,
    input  logic [31:0] rdata,
    input  logic [1:0]  rresp,
    input  logic        rvalid,
    output logic        rready,

    output logic        lookup_valid,
    output fetch_addr_t lookup_addr,
    input  logic        hit,
    input  logic [31:0] hit_data,

    output logic        fill_valid,
    output fetch_addr_t fill_addr,
    output logic [31:0] fill_data
);

    localparam logic [2:0] IDLE  = 3'd0;
    localparam logic [2:0] CHECK = 3'd1;
    localparam logic [2:0] ADDR  = 3'd2;
    localparam logic [2:0] DATA  = 3'd3;
    localparam logic [2:0] HOLD  = 3'd4;

    logic [2:0]  state;
    fetch_addr_t fetch_pc;
    logic        accept;
    logic        hit_check;
    logic        r_done;

    assign req_ready = (state == IDLE) && !flush; // Hold off during flush.
    assign accept = req_valid && req_ready;
    // Way outputs are valid once the lookup pulse has gone.
    assign hit_check = (state == CHECK) && !lookup_valid;
    assign r_done = (state == DATA) && rvalid;

    assign lookup_addr = fetch_pc;
    assign araddr = fetch_pc.raw;
    assign fill_addr = fetch_pc;
    assign fill_data = inst; // Holds rdata during the fill pulse.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
            lookup_valid <= 1'b0;
            arvalid <= 1'b0;
            rready <= 1'b0;
            inst_valid <= 1'b0;
            fill_valid <= 1'b0;
        end else begin
            lookup_valid <= 1'b0;
            fill_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (accept) begin
                        lookup_valid <= 1'b1;
                        state <= CHECK;
                    end
                end
                CHECK: begin
                    if (hit_check) begin
                        if (hit) begin
                            inst_valid <= 1'b1;
                            state <= HOLD;
                        end else begin
                            arvalid <= 1'b1;
                            state <= ADDR;
                        end
                    end
                end
                ADDR: begin
                    if (arready) begin
                        arvalid <= 1'b0;
                        rready <= 1'b1;
                        state <= DATA;
                    end
                end
                DATA: begin
                    if (rvalid) begin
                        rready <= 1'b0;
                        inst_valid <= 1'b1;
                        fill_valid <= (rresp == RESP_OKAY); // Faulted words stay out.
                        state <= HOLD;
                    end
                end
                HOLD: begin
                    if (inst_ready) begin
                        inst_valid <= 1'b0;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            fetch_pc.raw <= pc;
        end
        if (hit_check && hit) begin
            inst <= hit_data;
            inst_fault <= 1'b0;
        end
        if (r_done) begin
            inst <= rdata;
            inst_fault <= (rresp != RESP_OKAY);
        end
    end

    a_araddr_stable: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr));

    a_inst_stable: assert property (@(posedge clk) disable iff (rst)
        inst_valid && !inst_ready |=> inst_valid && $stable(inst) && $stable(inst_fault));

endmodule

/* hdl/fetch_top.sv */
module fetch_top import fetch_pkg::*; #(
    parameter int NUM_WAYS = 2
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        flush,

    input  logic        req_valid,
    output logic        req_ready,
    input  logic [31:0] pc,

    output logic        inst_valid,
    input  logic        inst_ready,
    output logic [31:0] inst,
    output logic        inst_fault,

    output logic [31:0] araddr,
    output logic        arvalid,
    input  logic        arready,
    input  logic [31:0] rdata,
    input  logic [1:0]  rresp,
    input  logic        rvalid,
    output logic        rready
);

    logic        lookup_valid;
    fetch_addr_t lookup_addr;
    logic        hit;
    logic [31:0] hit_data;
    logic        fill_valid;
    fetch_addr_t fill_addr;
    logic [31:0] fill_data;

    ifu u_ifu (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .pc           (pc),
        .inst_valid   (inst_valid),
        .inst_ready   (inst_ready),
        .inst         (inst),
        .inst_fault   (inst_fault),
        .araddr       (araddr),
        .arvalid      (arvalid),
        .arready      (arready),
        .rdata        (rdata),
        .rresp        (rresp),
        .rvalid       (rvalid),
        .rready       (rready),
        .lookup_valid (lookup_valid),
        .lookup_addr  (lookup_addr),
        .hit          (hit),
        .hit_data     (hit_data),
        .fill_valid   (fill_valid),
        .fill_addr    (fill_addr),
        .fill_data    (fill_data)
    );

    icache #(
        .NUM_WAYS (NUM_WAYS)
    ) u_icache (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .lookup_valid (lookup_valid),
        .lookup_addr  (lookup_addr),
        .hit          (hit),
        .hit_data     (hit_data),
        .fill_valid   (fill_valid),
        .fill_addr    (fill_addr),
        .fill_data    (fill_data)
    );

endmodule

/* tests/fetch_tb.sv */
module fetch_tb import fetch_pkg::*; ();

    localparam int NUM_ROWS = 18;
    localparam int RESET_CYCLES = 5;
    localparam int TIMEOUT_CYCLES = 60 * NUM_ROWS + RESET_CYCLES;
    localparam logic [1:0] RESP_SLVERR = 2'b10;
    localparam logic [31:0] MEM_KEY = 32'h5A5A_C3C3;

    logic        clk;
    logic        rst = 1'b1;
    logic        flush = 1'b0;
    logic        req_valid = 1'b0;
    logic        req_ready;
    logic [31:0] pc = '0;
    logic        inst_valid;
    logic        inst_ready = 1'b0;
    logic [31:0] inst;
    logic        inst_fault;
    logic [31:0] araddr;
    logic        arvalid;
    logic        arready = 1'b0;
    logic [31:0] rdata = '0;
    logic [1:0]  rresp = RESP_OKAY;
    logic        rvalid = 1'b0;
    logic        rready;

    logic [31:0] tbl_pc [NUM_ROWS];
    logic        tbl_flush [NUM_ROWS];
    logic        tbl_fault [NUM_ROWS];
    logic        tbl_axi [NUM_ROWS];
    int          row_count = 0;

    int          seed = 62940;
    int          errors = 0;
    int          rows_failed = 0;
    int          cycle_count = 0;
    int          axi_reads = 0;
    logic        rd_pending = 1'b0;
    logic [31:0] rd_addr_q = '0;
    int          ar_wait = 0;
    int          r_wait = 0;

    fetch_top #(
        .NUM_WAYS (2)
    ) fetch_top_inst (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .pc         (pc),
        .inst_valid (inst_valid),
        .inst_ready (inst_ready),
        .inst       (inst),
        .inst_fault (inst_fault),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic int rand_delay();
        return $random(seed) & 3; // Zero to three cycles.
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return addr ^ MEM_KEY;
    endfunction

    task automatic add_row(input logic [31:0] row_pc, input logic row_flush,
                           input logic row_fault, input logic row_axi);
        tbl_pc[row_count] = row_pc;
        tbl_flush[row_count] = row_flush;
        tbl_fault[row_count] = row_fault;
        tbl_axi[row_count] = row_axi;
        row_count++;
    endtask

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // AXI4-Lite read slave with random handshake delays.
    always @(posedge clk) begin
        if (rst) begin
            arready <= 1'b0;
            rvalid <= 1'b0;
            rd_pending <= 1'b0;
            ar_wait <= 0;
            r_wait <= 0;
            axi_reads <= 0;
        end else begin
            if (arvalid && arready) begin
                arready <= 1'b0;
                rd_pending <= 1'b1;
                rd_addr_q <= araddr;
                r_wait <= rand_delay();
                axi_reads <= axi_reads + 1;
            end else if (arvalid && !rd_pending) begin
                if (ar_wait == 0) begin
                    arready <= 1'b1;
                end else begin
                    ar_wait <= ar_wait - 1;
                end
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
                rd_pending <= 1'b0;
                ar_wait <= rand_delay();
            end else if (rd_pending && !rvalid) begin
                if (r_wait == 0) begin
                    rvalid <= 1'b1;
                    rdata <= mem_word(rd_addr_q);
                    rresp <= rd_addr_q[20] ? RESP_SLVERR : RESP_OKAY; // Bit 20 faults.
                end else begin
                    r_wait <= r_wait - 1;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: a fetch did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        int          delay;
        int          reads_before;
        int          errors_before;
        logic [31:0] held_inst;
        logic        held_fault;

        add_row(32'h0000_1000, 1'b0, 1'b0, 1'b1); // Cold miss, set 0 way 0.
        add_row(32'h0000_1000, 1'b0, 1'b0, 1'b0);
        add_row(32'h0000_2000, 1'b0, 1'b0, 1'b1); // Set 0 way 1.
        add_row(32'h0000_3000, 1'b0, 1'b0, 1'b1); // Evicts 0x1000 from way 0.
        add_row(32'h0000_2000, 1'b0, 1'b0, 1'b0);
        add_row(32'h0000_1000, 1'b0, 1'b0, 1'b1); // Evicts 0x2000 from way 1.
        add_row(32'h0000_3000, 1'b0, 1'b0, 1'b0);
        add_row(32'h0000_2000, 1'b0, 1'b0, 1'b1); // Evicts 0x3000 from way 0.
        add_row(32'h0010_1004, 1'b0, 1'b1, 1'b1); // SLVERR, not cached.
        add_row(32'h0010_1004, 1'b0, 1'b1, 1'b1);
        add_row(32'h0000_0044, 1'b0, 1'b0, 1'b1);
        add_row(32'h0000_0044, 1'b0, 1'b0, 1'b0);
        add_row(32'h0000_0048, 1'b0, 1'b0, 1'b1);
        add_row(32'h0000_0048, 1'b0, 1'b0, 1'b0);
        add_row(32'h0000_0044, 1'b1, 1'b0, 1'b1); // Flush first.
        add_row(32'h0000_1000, 1'b0, 1'b0, 1'b1);
        add_row(32'h0000_1000, 1'b0, 1'b0, 1'b0);
        add_row(32'h0000_0044, 1'b0, 1'b0, 1'b0);

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        for (int i = 0; i < row_count; i++) begin
            errors_before = errors;
            if (tbl_flush[i]) begin
                flush <= 1'b1;
                @(posedge clk);
                flush <= 1'b0;
            end
            reads_before = axi_reads;
            req_valid <= 1'b1;
            pc <= tbl_pc[i];
            @(posedge clk);
            while (!req_ready) @(posedge clk);
            req_valid <= 1'b0;

            @(posedge clk);
            while (!inst_valid) @(posedge clk);
            held_inst = inst;
            held_fault = inst_fault;
            delay = rand_delay();
            repeat (delay) begin
                @(posedge clk);
                compare("inst_valid held", 32'(inst_valid), 32'd1);
                compare("inst held", inst, held_inst);
                compare("inst_fault held", 32'(inst_fault), 32'(held_fault));
            end
            inst_ready <= 1'b1;
            @(posedge clk); // Transfer happens on this edge.
            inst_ready <= 1'b0;
            compare("inst_valid held", 32'(inst_valid), 32'd1);
            compare("inst held", inst, held_inst);
            compare("inst_fault held", 32'(inst_fault), 32'(held_fault));

            compare("inst", held_inst, mem_word(tbl_pc[i]));
            compare("inst_fault", 32'(held_fault), 32'(tbl_fault[i]));
            compare("AXI reads", 32'(axi_reads - reads_before), 32'(tbl_axi[i]));
            if (errors == errors_before) begin
                $display("Row %0d pc %h: ok", i, tbl_pc[i]);
            end else begin
                $display("Row %0d pc %h: FAILED", i, tbl_pc[i]);
                rows_failed++;
            end
        end

        $display("Rows run: %0d, rows failed: %0d, mismatches: %0d",
                 row_count, rows_failed, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* list.f */
common/fetch_pkg.sv
icache/icache_way.sv
icache/icache.sv
ifu/ifu.sv
hdl/fetch_top.sv
tests/fetch_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the fetch testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module fetch_tb -f list.f -o fetch_sim

./obj_dir/fetch_sim | tee sim.log

if grep -q "All tests passed!" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi
